// File: common/rr_pkg.sv
package rr_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////
  localparam int rr_addr_w = 32;
  localparam int rr_data_w = 32;
  localparam int rr_strb_w = rr_data_w / 8;

  // AXI4-Lite response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  ////////////////////////////////////////////////////////////
  // AXI4-Lite channel, split by driving side
  ////////////////////////////////////////////////////////////
  // Everything the master drives
  typedef struct packed {
    logic                 awvalid;
    logic [rr_addr_w-1:0] awaddr;
    logic                 wvalid;
    logic [rr_data_w-1:0] wdata;
    logic [rr_strb_w-1:0] wstrb;
    logic                 bready;
    logic                 arvalid;
    logic [rr_addr_w-1:0] araddr;
    logic                 rready;
  } axil_req_t;

  // Everything the slave drives
  typedef struct packed {
    logic                 awready;
    logic                 wready;
    logic                 bvalid;
    logic [1:0]           bresp;
    logic                 arready;
    logic                 rvalid;
    logic [rr_data_w-1:0] rdata;
    logic [1:0]           rresp;
  } axil_rsp_t;

  ////////////////////////////////////////////////////////////
  // Log entry word
  ////////////////////////////////////////////////////////////
  typedef enum logic {
    log_write = 1'b0,
    log_read  = 1'b1
  } rr_kind_e;

  // Kind sits in the top bit of both views
  typedef struct packed {
    rr_kind_e             kind;
    logic [rr_addr_w-1:0] addr;
    logic [rr_data_w-1:0] data;
    logic [rr_strb_w-1:0] strb;
    logic [1:0]           resp;
  } rr_wr_entry_t;

  // Read view, strobe slot is reserved and always zero
  typedef struct packed {
    rr_kind_e             kind;
    logic [rr_addr_w-1:0] addr;
    logic [rr_data_w-1:0] data;
    logic [rr_strb_w-1:0] rsvd;
    logic [1:0]           resp;
  } rr_rd_entry_t;

  typedef union packed {
    rr_wr_entry_t wr;
    rr_rd_entry_t rd;
  } rr_log_entry_u;

  ////////////////////////////////////////////////////////////
  // Control register map
  ////////////////////////////////////////////////////////////
  localparam logic [rr_addr_w-1:0] csr_mode_addr   = 32'h0;
  localparam logic [rr_addr_w-1:0] csr_state_addr  = 32'h4;
  localparam logic [rr_addr_w-1:0] csr_accept_addr = 32'h8;
  localparam logic [rr_addr_w-1:0] csr_drop_addr   = 32'hC;

endpackage

// File: src/rr_csrs.sv
module rr_csrs
  import rr_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  axil_req_t i_cfg_req,
  output axil_rsp_t o_cfg_rsp,
  input  logic      i_acc_pulse,
  input  logic      i_drop_pulse,
  output logic      o_record_en
);

  ////////////////////////////////////////////////////////////
  // Handshakes on the config port
  ////////////////////////////////////////////////////////////
  logic                 aw_got, w_got;
  logic [rr_addr_w-1:0] aw_addr_q;
  logic [rr_data_w-1:0] w_data_q;
  logic [rr_strb_w-1:0] w_strb_q;
  logic                 bvalid, rvalid;
  logic [1:0]           bresp, rresp;
  logic [rr_data_w-1:0] rdata;
  logic                 overflow;
  logic [31:0]          acc_cnt, drop_cnt;

  logic                 aw_hs, w_hs, ar_hs, wr_commit;
  logic [rr_addr_w-1:0] wr_addr;
  logic [rr_data_w-1:0] wr_data;
  logic [rr_strb_w-1:0] wr_strb;
  logic                 wr_known, ovf_clear;

  // A half-accepted write counts as pending, so each side takes one beat
  assign o_cfg_rsp.awready = !bvalid && !aw_got;
  assign o_cfg_rsp.wready  = !bvalid && !w_got;
  assign o_cfg_rsp.arready = !rvalid;
  assign o_cfg_rsp.bvalid  = bvalid;
  assign o_cfg_rsp.bresp   = bresp;
  assign o_cfg_rsp.rvalid  = rvalid;
  assign o_cfg_rsp.rdata   = rdata;
  assign o_cfg_rsp.rresp   = rresp;

  assign aw_hs = i_cfg_req.awvalid && o_cfg_rsp.awready;
  assign w_hs  = i_cfg_req.wvalid && o_cfg_rsp.wready;
  assign ar_hs = i_cfg_req.arvalid && o_cfg_rsp.arready;

  // Write completes in the cycle where both halves are in
  assign wr_commit = (aw_got || aw_hs) && (w_got || w_hs);
  assign wr_addr   = aw_hs ? i_cfg_req.awaddr : aw_addr_q;
  assign wr_data   = w_hs ? i_cfg_req.wdata : w_data_q;
  assign wr_strb   = w_hs ? i_cfg_req.wstrb : w_strb_q;
  assign wr_known  = (wr_addr == csr_mode_addr) || (wr_addr == csr_state_addr) ||
                     (wr_addr == csr_accept_addr) || (wr_addr == csr_drop_addr);
  // Write-one-to-clear on the state register
  assign ovf_clear = wr_commit && (wr_addr == csr_state_addr) &&
                     wr_strb[0] && wr_data[0];

  // Address and data of a write whose halves arrive apart
  always_ff @(posedge clk) begin
    if (aw_hs) aw_addr_q <= i_cfg_req.awaddr;
    if (w_hs) begin
      w_data_q <= i_cfg_req.wdata;
      w_strb_q <= i_cfg_req.wstrb;
    end
  end

  ////////////////////////////////////////////////////////////
  // Write side and register state
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_got      <= 1'b0;
      w_got       <= 1'b0;
      bvalid      <= 1'b0;
      bresp       <= resp_okay;
      o_record_en <= 1'b0;
      overflow    <= 1'b0;
      acc_cnt     <= '0;
      drop_cnt    <= '0;
    end else begin
      if (wr_commit) begin
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        bvalid <= 1'b1;
        bresp  <= wr_known ? resp_okay : resp_slverr;
      end else begin
        if (aw_hs) aw_got <= 1'b1;
        if (w_hs) w_got <= 1'b1;
        if (bvalid && i_cfg_req.bready) bvalid <= 1'b0;
      end
      if (wr_commit && (wr_addr == csr_mode_addr) && wr_strb[0])
        o_record_en <= wr_data[0];
      // A new drop wins over a clear in the same cycle
      overflow <= i_drop_pulse || (overflow && !ovf_clear);
      acc_cnt  <= acc_cnt + 32'(i_acc_pulse);
      drop_cnt <= drop_cnt + 32'(i_drop_pulse);
    end
  end

  ////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rvalid <= 1'b0;
      rresp  <= resp_okay;
      rdata  <= '0;
    end else if (ar_hs) begin
      rvalid <= 1'b1;
      rresp  <= resp_okay;
      case (i_cfg_req.araddr)
        csr_mode_addr:   rdata <= {31'b0, o_record_en};
        csr_state_addr:  rdata <= {31'b0, overflow};
        csr_accept_addr: rdata <= acc_cnt;
        csr_drop_addr:   rdata <= drop_cnt;
        default: begin
          rdata <= '0;
          rresp <= resp_slverr;
        end
      endcase
    end else if (rvalid && i_cfg_req.rready) begin
      rvalid <= 1'b0;
    end
  end

  // Every write response comes from a completed AW plus W pair
  a_bvalid_after_write: assert property (@(posedge clk) disable iff (!rstn)
    $rose(bvalid) |-> $past(wr_commit));

endmodule

// File: recorder/rr_axil_recorder.sv
module rr_axil_recorder
  import rr_pkg::*;
(
  input  logic          clk,
  input  logic          rstn,
  input  axil_req_t     i_sh_req,
  output axil_rsp_t     o_sh_rsp,
  output axil_req_t     o_cl_req,
  input  axil_rsp_t     i_cl_rsp,
  input  logic          i_record_en,
  output logic          o_rec_valid,
  output rr_log_entry_u o_rec_entry
);

  ////////////////////////////////////////////////////////////
  // Zero-latency pass-through
  ////////////////////////////////////////////////////////////
  assign o_cl_req = i_sh_req;
  assign o_sh_rsp = i_cl_rsp;

  // Handshakes seen on the wire
  logic aw_hs, w_hs, ar_hs, b_hs, r_hs;
  assign aw_hs = i_sh_req.awvalid && i_cl_rsp.awready;
  assign w_hs  = i_sh_req.wvalid && i_cl_rsp.wready;
  assign ar_hs = i_sh_req.arvalid && i_cl_rsp.arready;
  assign b_hs  = i_cl_rsp.bvalid && i_sh_req.bready;
  assign r_hs  = i_cl_rsp.rvalid && i_sh_req.rready;

  ////////////////////////////////////////////////////////////
  // Request side capture
  ////////////////////////////////////////////////////////////
  logic [rr_addr_w-1:0] aw_addr_q, ar_addr_q;
  logic [rr_data_w-1:0] w_data_q;
  logic [rr_strb_w-1:0] w_strb_q;

  // Held until the matching response
  always_ff @(posedge clk) begin
    if (aw_hs) aw_addr_q <= i_sh_req.awaddr;
    if (ar_hs) ar_addr_q <= i_sh_req.araddr;
    if (w_hs) begin
      w_data_q <= i_sh_req.wdata;
      w_strb_q <= i_sh_req.wstrb;
    end
  end

  ////////////////////////////////////////////////////////////
  // Entry build on completion
  ////////////////////////////////////////////////////////////
  logic          wr_fire, rd_fire;
  rr_log_entry_u wr_entry, rd_entry;

  assign wr_fire = b_hs && i_record_en;
  assign rd_fire = r_hs && i_record_en;

  always_comb begin
    wr_entry.wr.kind = log_write;
    wr_entry.wr.addr = aw_addr_q;
    wr_entry.wr.data = w_data_q;
    wr_entry.wr.strb = w_strb_q;
    wr_entry.wr.resp = i_cl_rsp.bresp;
    // Read data comes straight off the R beat
    rd_entry.rd.kind = log_read;
    rd_entry.rd.addr = ar_addr_q;
    rd_entry.rd.data = i_cl_rsp.rdata;
    rd_entry.rd.rsvd = '0;
    rd_entry.rd.resp = i_cl_rsp.rresp;
  end

  ////////////////////////////////////////////////////////////
  // Output register plus one-entry hold
  ////////////////////////////////////////////////////////////
  // Priority is hold, then write, then read
  logic          hold_valid;
  rr_log_entry_u hold_entry;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_rec_valid <= 1'b0;
      hold_valid  <= 1'b0;
    end else begin
      o_rec_valid <= hold_valid || wr_fire || rd_fire;
      // Second of any two sources waits one cycle
      hold_valid  <= (hold_valid && (wr_fire || rd_fire)) || (wr_fire && rd_fire);
    end
  end

  always_ff @(posedge clk) begin
    if (hold_valid) o_rec_entry <= hold_entry;
    else if (wr_fire) o_rec_entry <= wr_entry;
    else if (rd_fire) o_rec_entry <= rd_entry;
    if (hold_valid && wr_fire) hold_entry <= wr_entry;
    else if ((hold_valid || wr_fire) && rd_fire) hold_entry <= rd_entry;
  end

  ////////////////////////////////////////////////////////////
  // Shell protocol check
  ////////////////////////////////////////////////////////////
  // Open from AW handshake until its B handshake
  logic wr_pending;

  always_ff @(posedge clk) begin
    if (!rstn) wr_pending <= 1'b0;
    else if (aw_hs) wr_pending <= 1'b1;
    else if (b_hs) wr_pending <= 1'b0;
  end

  a_one_write_outstanding: assert property (@(posedge clk) disable iff (!rstn)
    aw_hs |-> !wr_pending);

endmodule

// File: recorder/rr_log_fifo.sv
module rr_log_fifo
  import rr_pkg::*;
#(
  parameter int log_depth = 4
) (
  input  logic          clk,
  input  logic          rstn,
  input  logic          i_rec_valid,
  input  rr_log_entry_u i_rec_entry,
  output logic          o_log_valid,
  output rr_log_entry_u o_log_entry,
  input  logic          i_log_ready,
  output logic          o_acc_pulse,
  output logic          o_drop_pulse
);

  localparam int ptr_w = (log_depth > 1) ? $clog2(log_depth) : 1;
  localparam int cnt_w = $clog2(log_depth + 1);

  ////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////
  rr_log_entry_u    mem [log_depth];
  logic [ptr_w-1:0] wr_ptr, rd_ptr;
  logic [cnt_w-1:0] count;
  logic             full, push, pop;

  assign full = (count == cnt_w'(log_depth));
  assign pop  = o_log_valid && i_log_ready;
  // A pop frees the slot in the same cycle, so full plus pop still accepts
  assign push = i_rec_valid && (!full || pop);

  assign o_acc_pulse  = push;
  assign o_drop_pulse = i_rec_valid && !push;

  // Oldest entry drives the stream
  assign o_log_valid = (count != '0);
  assign o_log_entry = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= i_rec_entry;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == ptr_w'(log_depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == ptr_w'(log_depth - 1)) ? '0 : rd_ptr + 1'b1;
      // Count moves only when exactly one side fires
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  a_count_bound: assert property (@(posedge clk) disable iff (!rstn)
    count <= cnt_w'(log_depth));

  // Stalled entry holds until taken
  a_stream_stable: assert property (@(posedge clk) disable iff (!rstn)
    o_log_valid && !i_log_ready |=> o_log_valid && $stable(o_log_entry));

endmodule

// File: src/rr_record_top.sv
module rr_record_top
  import rr_pkg::*;
#(
  parameter int log_depth = 4
) (
  input  logic          clk,
  input  logic          rstn,
  // Shell side
  input  axil_req_t     i_sh_req,
  output axil_rsp_t     o_sh_rsp,
  // User circuit side
  output axil_req_t     o_cl_req,
  input  axil_rsp_t     i_cl_rsp,
  // Control registers
  input  axil_req_t     i_cfg_req,
  output axil_rsp_t     o_cfg_rsp,
  // Log stream
  output logic          o_log_valid,
  output rr_log_entry_u o_log_entry,
  input  logic          i_log_ready
);

  ////////////////////////////////////////////////////////////
  // Stage 1, snoop the channel
  ////////////////////////////////////////////////////////////
  logic          record_en;
  logic          rec_valid;
  rr_log_entry_u rec_entry;

  rr_axil_recorder u_recorder (
    .clk         (clk),
    .rstn        (rstn),
    .i_sh_req    (i_sh_req),
    .o_sh_rsp    (o_sh_rsp),
    .o_cl_req    (o_cl_req),
    .i_cl_rsp    (i_cl_rsp),
    .i_record_en (record_en),
    .o_rec_valid (rec_valid),
    .o_rec_entry (rec_entry)
  );

  ////////////////////////////////////////////////////////////
  // Stage 2, buffer or drop
  ////////////////////////////////////////////////////////////
  logic acc_pulse, drop_pulse;

  rr_log_fifo #(
    .log_depth (log_depth)
  ) u_log_fifo (
    .clk          (clk),
    .rstn         (rstn),
    .i_rec_valid  (rec_valid),
    .i_rec_entry  (rec_entry),
    .o_log_valid  (o_log_valid),
    .o_log_entry  (o_log_entry),
    .i_log_ready  (i_log_ready),
    .o_acc_pulse  (acc_pulse),
    .o_drop_pulse (drop_pulse)
  );

  // Mode, overflow flag and counters
  rr_csrs u_csrs (
    .clk          (clk),
    .rstn         (rstn),
    .i_cfg_req    (i_cfg_req),
    .o_cfg_rsp    (o_cfg_rsp),
    .i_acc_pulse  (acc_pulse),
    .i_drop_pulse (drop_pulse),
    .o_record_en  (record_en)
  );

endmodule

// File: tests/rr_checker.sv
module rr_checker
  import rr_pkg::*;
#(
  parameter int log_depth = 4
) (
  input  logic          clk,
  input  logic          rstn,
  input  axil_req_t     i_sh_req,
  input  axil_rsp_t     i_sh_rsp,
  input  logic          i_log_valid,
  input  rr_log_entry_u i_log_entry,
  input  logic          i_log_ready,
  input  logic          i_rec_on,
  output int            o_errors,
  output int            o_tests,
  output int            o_failed,
  output int            o_pending,
  output int            o_acc,
  output int            o_drop
);
  timeunit 1ns;
  timeprecision 1ps;

  int    errors = 0;
  int    tests = 0;
  int    failed = 0;
  int    n_acc = 0;
  int    n_drop = 0;
  int    err_at_start = 0;
  string test_name = "none";

  // Entries on their way through the recorder, then the modelled buffer
  rr_log_entry_u pipe[$];
  rr_log_entry_u exp_q[$];

  logic [31:0] aw_addr, w_data, ar_addr;
  logic [3:0]  w_strb;

  assign o_errors  = errors;
  assign o_tests   = tests;
  assign o_failed  = failed;
  assign o_acc     = n_acc;
  assign o_drop    = n_drop;

  // Expected log word, kind on top, strobe slot zero for reads
  function automatic rr_log_entry_u rr_expect_entry(input logic is_read,
                                                    input logic [31:0] addr,
                                                    input logic [31:0] data,
                                                    input logic [3:0] strb,
                                                    input logic [1:0] resp);
    rr_log_entry_u e;
    e = {is_read, addr, data, (is_read ? 4'b0 : strb), resp};
    return e;
  endfunction

  ////////////////////////////////////////////////////////////
  // Test bookkeeping
  ////////////////////////////////////////////////////////////
  task automatic begin_test(input string name);
    test_name = name;
    err_at_start = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == err_at_start) begin
      $display("Test %s: ok", test_name);
    end else begin
      failed++;
      $display("Test %s: failed with %0d errors", test_name, errors - err_at_start);
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("Mismatch %s (%s) expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic note_error(input string msg);
    errors++;
    $display("Error in test %s: %s", test_name, msg);
  endtask

  ////////////////////////////////////////////////////////////
  // Monitor and compare
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    rr_log_entry_u e;
    if (!rstn) begin
      pipe.delete();
      exp_q.delete();
    end else begin
      // Log transfer against the oldest expected entry
      if (i_log_valid && i_log_ready) begin
        if (exp_q.size() == 0) begin
          note_error("a log entry came out that no transaction accounts for");
        end else begin
          e = exp_q.pop_front();
          if (e !== i_log_entry) begin
            errors++;
            $display("Mismatch %s expected %h actual %h", test_name, e, i_log_entry);
          end
        end
      end
      // One entry per cycle reaches the buffer, a full buffer drops it
      if (pipe.size() != 0) begin
        e = pipe.pop_front();
        if (exp_q.size() < log_depth) begin
          exp_q.push_back(e);
          n_acc++;
        end else begin
          n_drop++;
        end
      end
      if (i_sh_req.awvalid && i_sh_rsp.awready) aw_addr = i_sh_req.awaddr;
      if (i_sh_req.arvalid && i_sh_rsp.arready) ar_addr = i_sh_req.araddr;
      if (i_sh_req.wvalid && i_sh_rsp.wready) begin
        w_data = i_sh_req.wdata;
        w_strb = i_sh_req.wstrb;
      end
      // Write goes ahead of a read finishing on the same edge
      if (i_rec_on && i_sh_rsp.bvalid && i_sh_req.bready)
        pipe.push_back(rr_expect_entry(1'b0, aw_addr, w_data, w_strb, i_sh_rsp.bresp));
      if (i_rec_on && i_sh_rsp.rvalid && i_sh_req.rready)
        pipe.push_back(rr_expect_entry(1'b1, ar_addr, i_sh_rsp.rdata, 4'b0,
                                       i_sh_rsp.rresp));
    end
    o_pending = exp_q.size() + pipe.size();
  end

endmodule

// File: tests/tb_top.sv
module tb_top
  import rr_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int log_depth = 4;
  // 20 + 6 + 8 + 4 + 12 + 10 shell transactions
  localparam int n_planned = 60;
  localparam int watchdog_ns = n_planned * 40 * 8 + 2000;

  logic          clk;
  logic          rstn;
  axil_req_t     sh_req, cl_req, cfg_req;
  axil_rsp_t     sh_rsp, cl_rsp, cfg_rsp;
  logic          log_valid, log_ready, rec_on;
  rr_log_entry_u log_entry;
  int            errors, tests, failed, pending, chk_acc, chk_drop;

  rr_record_top #(.log_depth(log_depth)) DUT (
    .clk (clk), .rstn (rstn),
    .i_sh_req (sh_req), .o_sh_rsp (sh_rsp),
    .o_cl_req (cl_req), .i_cl_rsp (cl_rsp),
    .i_cfg_req (cfg_req), .o_cfg_rsp (cfg_rsp),
    .o_log_valid (log_valid), .o_log_entry (log_entry), .i_log_ready (log_ready)
  );

  rr_checker #(.log_depth(log_depth)) u_chk (
    .clk (clk), .rstn (rstn), .i_sh_req (sh_req), .i_sh_rsp (sh_rsp),
    .i_log_valid (log_valid), .i_log_entry (log_entry), .i_log_ready (log_ready),
    .i_rec_on (rec_on), .o_errors (errors), .o_tests (tests), .o_failed (failed),
    .o_pending (pending), .o_acc (chk_acc), .o_drop (chk_drop)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // User circuit model
  ////////////////////////////////////////////////////////////
  logic [31:0] mem [16];
  logic        aw_seen, w_seen, ar_seen, b_seen, r_seen, got_aw, got_w;
  logic [31:0] aw_addr_s, ar_addr_s, w_data_s, wa, wd;
  logic [3:0]  w_strb_s, ws;

  function automatic logic [1:0] resp_for(input logic [31:0] addr);
    return (addr >= 32'h100) ? resp_slverr : resp_okay;
  endfunction

  // Handshakes sampled on the rising edge, acted on at the falling edge
  always @(posedge clk) begin
    aw_seen   <= cl_req.awvalid && cl_rsp.awready;
    w_seen    <= cl_req.wvalid && cl_rsp.wready;
    ar_seen   <= cl_req.arvalid && cl_rsp.arready;
    b_seen    <= cl_rsp.bvalid && cl_req.bready;
    r_seen    <= cl_rsp.rvalid && cl_req.rready;
    aw_addr_s <= cl_req.awaddr;
    ar_addr_s <= cl_req.araddr;
    w_data_s  <= cl_req.wdata;
    w_strb_s  <= cl_req.wstrb;
  end

  always @(negedge clk) begin
    if (!rstn) begin
      cl_rsp = '0;
      got_aw = 1'b0;
      got_w  = 1'b0;
    end else begin
      if (b_seen) cl_rsp.bvalid = 1'b0;
      if (r_seen) cl_rsp.rvalid = 1'b0;
      if (aw_seen) begin
        got_aw = 1'b1;
        wa = aw_addr_s;
      end
      if (w_seen) begin
        got_w = 1'b1;
        wd = w_data_s;
        ws = w_strb_s;
      end
      if (got_aw && got_w && !cl_rsp.bvalid) begin
        if (wa < 32'h100) begin
          for (int b = 0; b < 4; b++)
            if (ws[b]) mem[wa[5:2]][8*b +: 8] = wd[8*b +: 8];
        end
        cl_rsp.bresp  = resp_for(wa);
        cl_rsp.bvalid = 1'b1;
        got_aw = 1'b0;
        got_w  = 1'b0;
      end
      if (ar_seen) begin
        cl_rsp.rvalid = 1'b1;
        cl_rsp.rresp  = resp_for(ar_addr_s);
        cl_rsp.rdata  = (ar_addr_s < 32'h100) ? mem[ar_addr_s[5:2]] : 32'h0;
      end
      // Random ready gaps
      cl_rsp.awready = !got_aw && !cl_rsp.bvalid && ($urandom % 4 != 0);
      cl_rsp.wready  = !got_w && !cl_rsp.bvalid && ($urandom % 4 != 0);
      cl_rsp.arready = !cl_rsp.rvalid && !ar_seen && ($urandom % 4 != 0);
    end
  end

  ////////////////////////////////////////////////////////////
  // Bus access tasks
  ////////////////////////////////////////////////////////////
  task automatic sh_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, output logic [1:0] resp);
    logic aw_done, w_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    @(negedge clk);
    sh_req.awvalid = 1'b1;
    sh_req.awaddr  = addr;
    sh_req.wvalid  = 1'b1;
    sh_req.wdata   = data;
    sh_req.wstrb   = strb;
    while (!(aw_done && w_done)) begin
      @(posedge clk);
      if (sh_req.awvalid && sh_rsp.awready) aw_done = 1'b1;
      if (sh_req.wvalid && sh_rsp.wready) w_done = 1'b1;
      @(negedge clk);
      if (aw_done) sh_req.awvalid = 1'b0;
      if (w_done) sh_req.wvalid = 1'b0;
    end
    repeat ($urandom % 3) @(negedge clk);
    sh_req.bready = 1'b1;
    do @(posedge clk); while (!sh_rsp.bvalid);
    resp = sh_rsp.bresp;
    @(negedge clk);
    sh_req.bready = 1'b0;
  endtask

  task automatic sh_read(input logic [31:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    @(negedge clk);
    sh_req.arvalid = 1'b1;
    sh_req.araddr  = addr;
    do @(posedge clk); while (!sh_rsp.arready);
    @(negedge clk);
    sh_req.arvalid = 1'b0;
    repeat ($urandom % 3) @(negedge clk);
    sh_req.rready = 1'b1;
    do @(posedge clk); while (!sh_rsp.rvalid);
    data = sh_rsp.rdata;
    resp = sh_rsp.rresp;
    @(negedge clk);
    sh_req.rready = 1'b0;
  endtask

  task automatic cfg_write(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk);
    cfg_req.awvalid = 1'b1;
    cfg_req.awaddr  = addr;
    cfg_req.wvalid  = 1'b1;
    cfg_req.wdata   = data;
    cfg_req.wstrb   = 4'hF;
    // Config block takes AW and W together when idle
    do @(posedge clk); while (!(cfg_rsp.awready && cfg_rsp.wready));
    @(negedge clk);
    cfg_req.awvalid = 1'b0;
    cfg_req.wvalid  = 1'b0;
    cfg_req.bready  = 1'b1;
    do @(posedge clk); while (!cfg_rsp.bvalid);
    u_chk.check_value("cfg bresp", 32'(resp_okay), 32'(cfg_rsp.bresp));
    @(negedge clk);
    cfg_req.bready = 1'b0;
  endtask

  task automatic cfg_read(input logic [31:0] addr, output logic [31:0] data);
    @(negedge clk);
    cfg_req.arvalid = 1'b1;
    cfg_req.araddr  = addr;
    do @(posedge clk); while (!cfg_rsp.arready);
    @(negedge clk);
    cfg_req.arvalid = 1'b0;
    cfg_req.rready  = 1'b1;
    do @(posedge clk); while (!cfg_rsp.rvalid);
    data = cfg_rsp.rdata;
    u_chk.check_value("cfg rresp", 32'(resp_okay), 32'(cfg_rsp.rresp));
    @(negedge clk);
    cfg_req.rready = 1'b0;
  endtask

  function automatic logic [31:0] random_addr();
    if ($urandom % 5 == 0) return 32'h100 + ((32'($urandom) % 16) << 2);
    return (32'($urandom) % 16) << 2;
  endfunction

  // One random write or read, optionally checked against the memory model
  task automatic random_access(input logic check);
    logic [31:0] addr, data, exp_data;
    logic [1:0]  resp;
    addr = random_addr();
    if ($urandom % 2 == 0) begin
      sh_write(addr, $urandom, 4'($urandom), resp);
      if (check) u_chk.check_value("bresp", 32'(resp_for(addr)), 32'(resp));
    end else begin
      exp_data = (addr < 32'h100) ? mem[addr[5:2]] : 32'h0;
      sh_read(addr, data, resp);
      if (check) begin
        u_chk.check_value("rdata", exp_data, data);
        u_chk.check_value("rresp", 32'(resp_for(addr)), 32'(resp));
      end
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (pending != 0 && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (pending != 0) begin
      u_chk.note_error("the log stream never delivered all entries");
    end else if (log_valid) begin
      u_chk.note_error("the log stream still offers an entry after all expected ones");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] d, rd;
    logic [1:0]  r, rr;
    int          acc0, drop0;
    void'($urandom(32'h121d_ac87));
    sh_req    = '0;
    cfg_req   = '0;
    cl_rsp    = '0;
    log_ready = 1'b1;
    rec_on    = 1'b0;
    rstn      = 1'b0;
    for (int i = 0; i < 16; i++) mem[i] = 32'h0;
    repeat (16) @(negedge clk);
    rstn = 1'b1;
    repeat (2) @(negedge clk);

    u_chk.begin_test("pass_through");
    repeat (20) random_access(1'b1);
    u_chk.end_test();

    u_chk.begin_test("record_disabled");
    repeat (6) random_access(1'b0);
    repeat (10) @(negedge clk);
    cfg_read(csr_accept_addr, d);
    u_chk.check_value("accepted", 32'h0, d);
    u_chk.end_test();

    cfg_write(csr_mode_addr, 32'h1);
    rec_on = 1'b1;
    u_chk.begin_test("write_entries");
    repeat (8) sh_write(random_addr(), $urandom, 4'($urandom), r);
    wait_drained();
    u_chk.end_test();

    u_chk.begin_test("read_entries");
    repeat (4) sh_read(random_addr(), d, r);
    // Overlapping pairs so B and R can finish together
    repeat (6) begin
      fork
        sh_write(random_addr(), $urandom, 4'($urandom), r);
        sh_read(random_addr(), rd, rr);
      join
    end
    wait_drained();
    u_chk.end_test();

    u_chk.begin_test("backpressure");
    @(negedge clk);
    log_ready = 1'b0;
    acc0  = chk_acc;
    drop0 = chk_drop;
    repeat (10) sh_write(random_addr(), $urandom, 4'($urandom), r);
    repeat (5) @(negedge clk);
    u_chk.check_value("log valid held", 32'h1, 32'(log_valid));
    cfg_read(csr_accept_addr, d);
    u_chk.check_value("accepted", 32'(acc0 + log_depth), d);
    cfg_read(csr_drop_addr, d);
    u_chk.check_value("dropped", 32'(drop0 + 10 - log_depth), d);
    cfg_read(csr_state_addr, d);
    u_chk.check_value("overflow set", 32'h1, d);
    cfg_write(csr_state_addr, 32'h1);
    cfg_read(csr_state_addr, d);
    u_chk.check_value("overflow cleared", 32'h0, d);
    @(negedge clk);
    log_ready = 1'b1;
    wait_drained();
    u_chk.end_test();

    $display("Tests run %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0 && failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdog_ns);
    $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: all.f
common/rr_pkg.sv
src/rr_csrs.sv
recorder/rr_axil_recorder.sv
recorder/rr_log_fifo.sv
src/rr_record_top.sv
tests/rr_checker.sv
tests/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f all.f --top-module tb_top -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
